// ==== include/core_defines.svh ====
// Core width and sizing macros, included by the packages and RTL modules that need them
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and instruction word width
`define WORD_BITS 32

// Register index width and register file depth
`define REG_IDX_BITS 5
`define REG_COUNT 32

// MOVI immediate, sign-extended to a word
`define IMM_BITS 20

// Radix-16 multiplier: bits per step and step count
`define MUL_DIGIT_BITS 4
`define MUL_STEPS (`WORD_BITS / `MUL_DIGIT_BITS)

// Instruction word that does nothing
`define NOP_WORD 32'hffff_ffff

`endif

// ==== logic/isaPkg.sv ====
// Instruction-set types shared by the decoder, issue bus and execute datapath
`include "core_defines.svh"

package isaPkg;

  // Data word and register index
  typedef logic [`WORD_BITS-1:0] wordT;
  typedef logic [`REG_IDX_BITS-1:0] regIdxT;

  // MOVI immediate field, bits 19..0
  typedef logic [`IMM_BITS-1:0] immT;

  // Opcode field, bits 31..25 of the instruction
  // Remaining fields: dst 24..20, src1 19..15, src2 14..10
  typedef enum logic [6:0] {
    opAdd  = 7'h00,
    opSub  = 7'h01,
    opMul  = 7'h02,
    opMov  = 7'h14,
    opMovi = 7'h15,
    opNop  = 7'h7f
  } opcodeT;

endpackage

// ==== logic/pipePkg.sv ====
// Microarchitecture types for the issue controller and multiplier step timer
`include "core_defines.svh"

package pipePkg;

  // Issue controller states
  typedef enum logic {
    stIdle,
    stMulRun
  } issueStateT;

  // Step counter, must hold MUL_STEPS itself
  typedef logic [$clog2(`MUL_STEPS + 1)-1:0] stepCountT;

endpackage

// ==== logic/issueBus.sv ====
// Issued operation passed from the operand stage to the execute stage
`timescale 1ns/1ps

interface issueBus;

  // One-cycle strobe per issued operation
  logic valid;
  // Decoded opcode, undefined ones already folded to NOP
  isaPkg::opcodeT op;
  isaPkg::regIdxT dst;
  // Operands after bypass, immediate already on srcA for MOVI
  isaPkg::wordT srcA;
  isaPkg::wordT srcB;

  // Operand stage side
  modport producer (
    output valid, op, dst, srcA, srcB
  );

  // Execute stage side
  modport consumer (
    input valid, op, dst, srcA, srcB
  );

endinterface

// ==== logic/issueControl.sv ====
// Issue FSM that accepts instructions and holds busy for the length of a multiply
`timescale 1ns/1ps

module issueControl (
  input  logic clk,
  input  logic rst,
  input  logic instValid,
  input  logic instIsMul,
  input  logic lastStep,
  output logic accept,
  output logic startMul,
  output logic busy
);

  pipePkg::issueStateT state;
  pipePkg::issueStateT stateNext;

  // Only idle takes new work
  assign busy = (state == pipePkg::stMulRun);
  assign accept = instValid && (state == pipePkg::stIdle);

  // Kicks the step timer on the acceptance edge
  assign startMul = accept && instIsMul;

  always_comb
  begin
    stateNext = state;
    case (state)
      pipePkg::stIdle:
      begin
        // Accepted multiply locks out issue
        if (startMul)
        begin
          stateNext = pipePkg::stMulRun;
        end
      end
      pipePkg::stMulRun:
      begin
        // Product lands in writeback on this edge
        if (lastStep)
        begin
          stateNext = pipePkg::stIdle;
        end
      end
      default:
      begin
        stateNext = pipePkg::stIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= pipePkg::stIdle;
    end
    else
    begin
      state <= stateNext;
    end
  end

endmodule

// ==== logic/mulStepTimer.sv ====
// Down-counter that paces the shift-add multiplier and flags its final step
`timescale 1ns/1ps
`include "core_defines.svh"

module mulStepTimer (
  input  logic clk,
  input  logic rst,
  input  logic load,
  output logic step,
  output logic lastStep
);

  pipePkg::stepCountT count;

  // One multiplier step per edge while nonzero
  assign step = (count != '0);
  assign lastStep = (count == pipePkg::stepCountT'(1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (load)
    begin
      count <= pipePkg::stepCountT'(`MUL_STEPS);
    end
    else if (step)
    begin
      count <= count - pipePkg::stepCountT'(1);
    end
  end

endmodule

// ==== logic/operandStage.sv ====
// Operand stage: decodes the instruction, reads registers with bypass, fills the issue register
`timescale 1ns/1ps
`include "core_defines.svh"

module operandStage (
  input  logic           clk,
  input  logic           rst,
  input  isaPkg::wordT   inst,
  input  logic           accept,
  input  logic           wbValid,
  input  isaPkg::regIdxT wbDst,
  input  isaPkg::wordT   wbData,
  input  isaPkg::regIdxT exDst,
  input  isaPkg::wordT   exData,
  input  logic           exWrites,
  output logic           instIsMul,
  issueBus.producer      iss
);

  isaPkg::wordT rf [`REG_COUNT];

  // Instruction fields
  logic [6:0]     opField;
  isaPkg::regIdxT dstIdx;
  isaPkg::regIdxT srcIdxA;
  isaPkg::regIdxT srcIdxB;
  isaPkg::immT    immField;

  isaPkg::opcodeT decOp;
  isaPkg::wordT   immExt;
  isaPkg::wordT   operandA;
  isaPkg::wordT   operandB;

  // Issue register result wins, it has not reached writeback yet
  function automatic isaPkg::wordT bypassRead(
    input isaPkg::regIdxT idx,
    input isaPkg::wordT   rfVal,
    input logic           exHit,
    input isaPkg::regIdxT exIdx,
    input isaPkg::wordT   exVal,
    input logic           wbHit,
    input isaPkg::regIdxT wbIdx,
    input isaPkg::wordT   wbVal
  );
    isaPkg::wordT result;
    result = rfVal;
    if (exHit && (exIdx == idx))
    begin
      result = exVal;
    end
    // Write-through of the port being written this edge
    else if (wbHit && (wbIdx == idx))
    begin
      result = wbVal;
    end
    return result;
  endfunction

  assign opField = inst[31:25];
  assign dstIdx = inst[24:20];
  assign srcIdxA = inst[19:15];
  assign srcIdxB = inst[14:10];
  assign immField = inst[`IMM_BITS-1:0];

  // Undefined opcodes issue as NOP
  always_comb
  begin
    case (opField)
      isaPkg::opAdd, isaPkg::opSub, isaPkg::opMul, isaPkg::opMov, isaPkg::opMovi:
      begin
        decOp = isaPkg::opcodeT'(opField);
      end
      default:
      begin
        decOp = isaPkg::opNop;
      end
    endcase
  end

  // Only place the opcode is examined for the controller
  assign instIsMul = (decOp == isaPkg::opMul);

  // Sign extend MOVI immediate
  assign immExt = {{(`WORD_BITS - `IMM_BITS){immField[`IMM_BITS-1]}}, immField};

  assign operandA = bypassRead(srcIdxA, rf[srcIdxA], exWrites, exDst, exData,
                               wbValid, wbDst, wbData);
  assign operandB = bypassRead(srcIdxB, rf[srcIdxB], exWrites, exDst, exData,
                               wbValid, wbDst, wbData);

  // Registers read zero after reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
      begin
        rf[i] <= '0;
      end
    end
    else if (wbValid)
    begin
      rf[wbDst] <= wbData;
    end
  end

  // Issue strobe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      iss.valid <= 1'b0;
    end
    else
    begin
      iss.valid <= accept;
    end
  end

  // Issue payload, loaded only on acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      iss.op <= decOp;
      iss.dst <= dstIdx;
      iss.srcA <= (decOp == isaPkg::opMovi) ? immExt : operandA;
      iss.srcB <= operandB;
    end
  end

endmodule

// ==== logic/executeStage.sv ====
// Execute stage: single-cycle ALU, radix-16 shift-add multiplier and the writeback register
`timescale 1ns/1ps
`include "core_defines.svh"

module executeStage (
  input  logic            clk,
  input  logic            rst,
  issueBus.consumer       iss,
  input  logic            step,
  input  logic            lastStep,
  output isaPkg::regIdxT  exDst,
  output isaPkg::wordT    exData,
  output logic            exWrites,
  output logic            wbValid,
  output isaPkg::regIdxT  wbDst,
  output isaPkg::wordT    wbData
);

  isaPkg::wordT aluResult;
  logic         aluWrites;

  // Multiplier state
  isaPkg::wordT   mulPart;
  isaPkg::wordT   mulCand;
  isaPkg::wordT   mulRest;
  isaPkg::regIdxT mulDst;

  // First step takes operands straight off the issue bus
  logic                       mulFirst;
  logic [`MUL_DIGIT_BITS-1:0] mulDigit;
  isaPkg::wordT               mulBase;
  isaPkg::wordT               mulAcc;
  isaPkg::wordT               mulShiftSrc;
  isaPkg::wordT               mulSum;

  always_comb
  begin
    aluResult = iss.srcA;
    aluWrites = 1'b0;
    case (iss.op)
      isaPkg::opAdd:
      begin
        aluResult = iss.srcA + iss.srcB;
        aluWrites = 1'b1;
      end
      isaPkg::opSub:
      begin
        aluResult = iss.srcA - iss.srcB;
        aluWrites = 1'b1;
      end
      // MOVI immediate already sits on srcA
      isaPkg::opMov, isaPkg::opMovi:
      begin
        aluResult = iss.srcA;
        aluWrites = 1'b1;
      end
      default:
      begin
        aluWrites = 1'b0;
      end
    endcase
  end

  // Visible to operand stage for bypass
  assign exDst = iss.dst;
  assign exData = aluResult;
  assign exWrites = iss.valid && aluWrites;

  assign mulFirst = iss.valid && (iss.op == isaPkg::opMul);
  assign mulShiftSrc = mulFirst ? iss.srcB : mulRest;
  assign mulDigit = mulShiftSrc[`MUL_DIGIT_BITS-1:0];
  assign mulBase = mulFirst ? iss.srcA : mulCand;
  assign mulAcc = mulFirst ? '0 : mulPart;

  // Low word only, upper partial bits drop out
  assign mulSum = mulAcc + (isaPkg::wordT'(mulDigit) * mulBase);

  // Multiplicand moves up one digit per step, multiplier moves down
  always_ff @(posedge clk)
  begin
    if (step)
    begin
      mulPart <= mulSum;
      mulCand <= mulBase << `MUL_DIGIT_BITS;
      mulRest <= mulShiftSrc >> `MUL_DIGIT_BITS;
      if (mulFirst)
      begin
        mulDst <= iss.dst;
      end
    end
  end

  // Writeback strobe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wbValid <= 1'b0;
    end
    else
    begin
      wbValid <= lastStep || exWrites;
    end
  end

  // Busy keeps ALU issue away from the last multiply step
  always_ff @(posedge clk)
  begin
    if (lastStep)
    begin
      wbDst <= mulDst;
      wbData <= mulSum;
    end
    else if (exWrites)
    begin
      wbDst <= iss.dst;
      wbData <= aluResult;
    end
  end

endmodule

// ==== logic/procCore.sv ====
// Integer execution core top level, takes instruction strobes and emits writeback strobes
`timescale 1ns/1ps

module procCore (
  input  logic           clk,
  input  logic           rst,
  input  logic           instValid,
  input  isaPkg::wordT   inst,
  output logic           busy,
  output logic           wbValid,
  output isaPkg::regIdxT wbDst,
  output isaPkg::wordT   wbData
);

  // Controller to operand stage
  logic accept;
  logic startMul;
  logic instIsMul;

  // Step timer to controller and multiplier
  logic step;
  logic lastStep;

  // Issue register result for bypass
  isaPkg::regIdxT exDst;
  isaPkg::wordT   exData;
  logic           exWrites;

  issueBus iss ();

  // Acceptance and busy while a multiply runs
  issueControl u_issueControl (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .instIsMul (instIsMul),
    .lastStep  (lastStep),
    .accept    (accept),
    .startMul  (startMul),
    .busy      (busy)
  );

  // Counts multiplier steps from the accepted MUL
  mulStepTimer u_mulStepTimer (
    .clk      (clk),
    .rst      (rst),
    .load     (startMul),
    .step     (step),
    .lastStep (lastStep)
  );

  // Decode, register file, bypass, issue register
  operandStage u_operandStage (
    .clk       (clk),
    .rst       (rst),
    .inst      (inst),
    .accept    (accept),
    .wbValid   (wbValid),
    .wbDst     (wbDst),
    .wbData    (wbData),
    .exDst     (exDst),
    .exData    (exData),
    .exWrites  (exWrites),
    .instIsMul (instIsMul),
    .iss       (iss.producer)
  );

  // ALU, multiplier, writeback register
  executeStage u_executeStage (
    .clk      (clk),
    .rst      (rst),
    .iss      (iss.consumer),
    .step     (step),
    .lastStep (lastStep),
    .exDst    (exDst),
    .exData   (exData),
    .exWrites (exWrites),
    .wbValid  (wbValid),
    .wbDst    (wbDst),
    .wbData   (wbData)
  );

endmodule

// ==== sim/resultChecker.sv ====
// Scoreboard for the core testbench, checks writeback order, values, latency and busy
`timescale 1ns/1ps
`include "core_defines.svh"

module resultChecker (
  input  logic           clk,
  input  logic           rst,
  input  logic           busy,
  input  logic           wbValid,
  input  isaPkg::regIdxT wbDst,
  input  isaPkg::wordT   wbData,
  input  logic           pushValid,
  input  isaPkg::regIdxT pushDst,
  input  isaPkg::wordT   pushData,
  input  logic           pushIsMul,
  output int             errorCount,
  output int             checkCount,
  output int             wbCount,
  output int             pending
);

  // Outstanding results in acceptance order
  isaPkg::regIdxT expDst [$];
  isaPkg::wordT   expData [$];
  logic           expIsMul [$];
  int             expEdge [$];

  // Rising edges seen so far
  int edgeCount = 0;

  int errors = 0;
  int checks = 0;
  int pulses = 0;
  int queued = 0;

  assign errorCount = errors;
  assign checkCount = checks;
  assign wbCount = pulses;
  assign pending = queued;

  always @(posedge clk)
  begin
    edgeCount <= edgeCount + 1;
  end

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
    end
  endtask

  // Busy must cover every multiply still in flight
  function automatic logic mulOutstanding();
    logic found;
    found = 1'b0;
    foreach (expIsMul[k])
    begin
      found = found | expIsMul[k];
    end
    return found;
  endfunction

  task automatic checkWriteback();
    int latency;
    int want;
    pulses++;
    if (expDst.size() == 0)
    begin
      errors++;
      $display("Writeback to r%0d at t=%0t with no instruction outstanding", wbDst, $time);
    end
    else
    begin
      // Edges from acceptance to the writeback strobe
      latency = edgeCount - expEdge[0];
      want = expIsMul[0] ? `MUL_STEPS : 1;
      compareValue("wbDst", 32'(wbDst), 32'(expDst[0]));
      compareValue("wbData", wbData, expData[0]);
      compareValue("wbValid latency", latency, want);
      void'(expDst.pop_front());
      void'(expData.pop_front());
      void'(expIsMul.pop_front());
      void'(expEdge.pop_front());
    end
  endtask

  // Outputs change on rising edges, so sample mid-cycle
  always @(negedge clk)
  begin
    if (rst)
    begin
      // Registers hold reset after the first edge
      if (edgeCount > 0)
      begin
        compareValue("busy", 32'(busy), 32'd0);
        compareValue("wbValid", 32'(wbValid), 32'd0);
      end
    end
    else
    begin
      if (wbValid === 1'b1)
      begin
        checkWriteback();
      end
      else if (wbValid !== 1'b0)
      begin
        compareValue("wbValid", 32'(wbValid), 32'd0);
      end
      // Acceptance was the last rising edge
      if (pushValid)
      begin
        expDst.push_back(pushDst);
        expData.push_back(pushData);
        expIsMul.push_back(pushIsMul);
        expEdge.push_back(edgeCount);
      end
      compareValue("busy", 32'(busy), 32'(mulOutstanding()));
    end
    queued = expDst.size();
  end

endmodule

// ==== sim/procCore_tb.sv ====
// Testbench top for the execution core, plays the stim program and reports the outcome
`timescale 1ns/1ps
`include "core_defines.svh"

module procCore_tb;

  localparam int stimCount = 24;
  // Worst case per entry is an idle gap plus a full multiply
  localparam int watchdogCycles = stimCount * (`MUL_STEPS + 5) + 50;

  logic           clk;
  logic           rst;
  logic           instValid;
  isaPkg::wordT   inst;
  logic           busy;
  logic           wbValid;
  isaPkg::regIdxT wbDst;
  isaPkg::wordT   wbData;

  // Expectation handed to the checker, one cycle per accepted writer
  logic           pushValid;
  isaPkg::regIdxT pushDst;
  isaPkg::wordT   pushData;
  logic           pushIsMul;

  int errorCount;
  int checkCount;
  int wbCount;
  int pending;

  // Instruction in the high word, expected result in the low word
  logic [63:0] stim [stimCount];
  logic [31:0] lfsr;
  int          gap;
  int          pushCount;
  logic        loadError;

  procCore u_procCore (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .inst      (inst),
    .busy      (busy),
    .wbValid   (wbValid),
    .wbDst     (wbDst),
    .wbData    (wbData)
  );

  resultChecker u_resultChecker (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .wbValid    (wbValid),
    .wbDst      (wbDst),
    .wbData     (wbData),
    .pushValid  (pushValid),
    .pushDst    (pushDst),
    .pushData   (pushData),
    .pushIsMul  (pushIsMul),
    .errorCount (errorCount),
    .checkCount (checkCount),
    .wbCount    (wbCount),
    .pending    (pending)
  );

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Two LFSR bits give 0 to 3 idle cycles
  task automatic drawGap(output int cycles);
    cycles = 0;
    repeat (2)
    begin
      lfsr = lfsrNext(lfsr);
      cycles = (cycles << 1) | int'(lfsr[0]);
    end
  endtask

  // ADD, SUB, MUL, MOV, MOVI write a register
  function automatic logic writesResult(input logic [6:0] op);
    case (op)
      7'h00, 7'h01, 7'h02, 7'h14, 7'h15: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Drive point is 2 ns after each rising edge
  task automatic nextCycle();
    @(posedge clk);
    #2;
    pushValid = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  initial
  begin
    rst = 1'b1;
    instValid = 1'b0;
    inst = `NOP_WORD;
    pushValid = 1'b0;
    pushDst = '0;
    pushData = '0;
    pushIsMul = 1'b0;
    lfsr = 32'hc0ea4bdd;
    pushCount = 0;
    gap = 0;
    $readmemh("sim/stimProgram.hex", stim);
    loadError = $isunknown(stim[stimCount-1]);
    if (loadError)
    begin
      $display("Stimulus file sim/stimProgram.hex is missing or too short");
    end
    repeat (8) nextCycle();
    rst = 1'b0;

    for (int i = 0; i < stimCount && !loadError; i++)
    begin
      drawGap(gap);
      instValid = 1'b0;
      inst = `NOP_WORD;
      repeat (gap) nextCycle();
      instValid = 1'b1;
      inst = stim[i][63:32];
      // Busy at mid-cycle decides the coming edge
      @(negedge clk);
      while (busy)
      begin
        nextCycle();
        @(negedge clk);
      end
      // Acceptance edge
      nextCycle();
      if (writesResult(stim[i][63:57]))
      begin
        pushValid = 1'b1;
        pushDst = stim[i][56:52];
        pushData = stim[i][31:0];
        pushIsMul = (stim[i][63:57] == 7'h02);
        pushCount++;
      end
    end
    instValid = 1'b0;
    inst = `NOP_WORD;

    // Let the checker take the last push, drain, then watch for stray strobes
    repeat (2) nextCycle();
    while (pending != 0)
    begin
      nextCycle();
    end
    repeat (`MUL_STEPS + 4) nextCycle();

    if (wbCount != pushCount)
    begin
      $display("Saw %0d writebacks but %0d results were expected", wbCount, pushCount);
    end
    $display("Checks %0d, errors %0d, writebacks %0d, expected writebacks %0d",
             checkCount, errorCount, wbCount, pushCount);
    if (errorCount == 0 && wbCount == pushCount && !loadError)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Timeout after %0d cycles, the program did not complete", watchdogCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
logic/isaPkg.sv
logic/pipePkg.sv
logic/issueBus.sv
logic/issueControl.sv
logic/mulStepTimer.sv
logic/operandStage.sv
logic/executeStage.sv
logic/procCore.sv
sim/resultChecker.sv
sim/procCore_tb.sv

// ==== Makefile ====
# Verilator build and run for the execution core testbench

SIM       = verilator
SIMFLAGS  = --binary --timing -Wno-fatal
TOP       = procCore_tb
FILELIST  = all.f
OBJDIR    = obj_dir
PASS_TEXT = TESTBENCH PASSED

BIN     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) include/core_defines.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Exit status follows the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// ==== sim/stimProgram.hex ====
// Columns: instruction word (high 32 bits), expected writeback data (low 32 bits)
// NOP and undefined opcodes carry a zero result that is never checked
00110C0000000000
2A21234500012345
2A3FFFFFFFFFFFFF
00410C0000012344
02520800FFFFFFFF
00629400FFFFFFFE
28730000FFFFFFFE
2A880000FFF80000
02941C00FFF80002
04A110004B64CD54
00B508004B65F099
04C1A00000080000
04D6240000100000
FFFFFFFF00000000
66E0000000000000
00F7040000000000
2B07FFFF0007FFFF
05184000FFF00001
0328C000FFE80002
00094800FFD00004
29300000FFD00004
05499400002FFFFC
FC00000000000000
015A2C004B95F095
